//--- hdl/tpu_types_pkg.sv
// Tile-wide data types
// Memory word and word-address widths shared by the tensor tile

package tpu_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	localparam int WORD_WIDTH    = 32;			// Bits per memory word
	localparam int ADDRESS_WIDTH = 16;			// Bits per word address

	////////////////////////////////////////////////////////////////////////////
	// Types

	// One data memory word
	typedef logic [WORD_WIDTH-1:0]    data_t;

	// Word address, stride or beat count
	// Wider than the memory, so addresses wrap modulo its depth
	typedef logic [ADDRESS_WIDTH-1:0] address_t;

endpackage

//--- hdl/dmem_pkg.sv
// Data memory controller definitions
// Burst descriptor carried with each request, and arbiter states

package dmem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Burst descriptor

	// Beat i goes to base + i * stride, modulo the memory depth
	typedef struct packed {
		tpu_types_pkg::address_t	base;			// First word address
		tpu_types_pkg::address_t	stride;			// Step between beats
		tpu_types_pkg::address_t	length;			// Beats in burst, 0 means 1
	} burst_req_t;

	////////////////////////////////////////////////////////////////////////////
	// Arbiter FSM

	typedef enum logic {
		ARB_IDLE = 1'b0,							// No burst running
		ARB_BUSY = 1'b1								// Grant held until burst end
	} arb_state_t;

endpackage

//--- hdl/request_arbiter.sv
// Burst request arbiter
// Holds one pending burst per client and grants one at a time, round robin

`timescale 1ns/10ps

module request_arbiter
	import dmem_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			req			[2],	// One-cycle request strobe
	input	burst_req_t		req_desc	[2],	// Valid with the strobe
	input	logic			burst_end,			// Last beat of granted burst
	output	logic			grant		[2],	// Held for the whole burst
	output	burst_req_t		active_desc,		// Winner, valid with burst_start
	output	logic			burst_start			// Loads the address generator
);

	arb_state_t		state;
	logic			pending		[2];
	burst_req_t		held_desc	[2];
	logic			last_winner;

	logic			avail		[2];
	burst_req_t		cand_desc	[2];
	logic			winner;

	////////////////////////////////////////////////////////////////////////////
	// Candidate selection

	// A strobe in this cycle counts as pending already
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			avail[i]     = pending[i] | req[i];
			cand_desc[i] = req[i] ? req_desc[i] : held_desc[i];
		end
	end

	assign winner      = (avail[0] & avail[1]) ? ~last_winner : avail[1];	// Round robin
	assign burst_start = (state == ARB_IDLE) & (avail[0] | avail[1]);
	assign active_desc = cand_desc[winner];

	////////////////////////////////////////////////////////////////////////////
	// Descriptor store

	always_ff @(posedge clock) begin
		for (int i = 0; i < 2; i++) begin
			if (req[i]) begin
				held_desc[i] <= req_desc[i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Grant FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= ARB_IDLE;
			last_winner <= 1'b1;					// Client 0 wins the first tie
			pending[0]  <= 1'b0;
			pending[1]  <= 1'b0;
			grant[0]    <= 1'b0;
			grant[1]    <= 1'b0;
		end
		else begin
			for (int i = 0; i < 2; i++) begin
				pending[i] <= avail[i] & ~(burst_start & (winner == 1'(i)));
			end

			case (state)
				ARB_IDLE: begin
					if (burst_start) begin
						state       <= ARB_BUSY;
						last_winner <= winner;
						grant[0]    <= ~winner;
						grant[1]    <= winner;
					end
				end
				ARB_BUSY: begin
					if (burst_end) begin
						state    <= ARB_IDLE;			// Next grant one cycle later
						grant[0] <= 1'b0;
						grant[1] <= 1'b0;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/agu.sv
// Strided address generator
// Walks base + i * stride over the burst beats and flags the last beat

`timescale 1ns/10ps

module agu
	import tpu_types_pkg::*;
	import dmem_pkg::*;
#(
	parameter int DMEM_DEPTH = 256					// Power of two, up to 65536
)(
	input	logic			clock,
	input	logic			reset,
	input	logic			start,				// Load a new descriptor
	input	burst_req_t		desc,
	input	logic			beat,				// Grant and valid both high
	output	address_t		address,			// Valid during beats
	output	logic			end_access			// High on the final beat
);

	localparam address_t ADDR_MASK = address_t'(DMEM_DEPTH - 1);

	address_t		current_address;
	address_t		step;
	address_t		remaining;

	////////////////////////////////////////////////////////////////////////////
	// Outputs

	assign address    = current_address;
	assign end_access = beat & (remaining == address_t'(1));

	////////////////////////////////////////////////////////////////////////////
	// Address walk

	always_ff @(posedge clock) begin
		if (start) begin
			current_address <= desc.base & ADDR_MASK;
			step            <= desc.stride;
		end
		else if (beat) begin
			current_address <= (current_address + step) & ADDR_MASK;	// Wraps at depth
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Beat counter

	always_ff @(posedge clock) begin
		if (reset) begin
			remaining <= '0;
		end
		else if (start) begin
			// Zero length still makes one beat
			if (desc.length == '0) begin
				remaining <= address_t'(1);
			end
			else begin
				remaining <= desc.length;
			end
		end
		else if (beat && (remaining != '0)) begin
			remaining <= remaining - address_t'(1);
		end
	end

endmodule

//--- hdl/dmem_array.sv
// Tile data memory
// One write port and one registered read port

`timescale 1ns/10ps

module dmem_array
	import tpu_types_pkg::*;
#(
	parameter int DMEM_DEPTH = 256
)(
	input	logic			clock,
	input	logic			write_en,
	input	address_t		write_address,
	input	data_t			write_data,
	input	logic			read_en,
	input	address_t		read_address,
	output	data_t			read_data			// One cycle after read_en
);

	localparam int INDEX_BITS = $clog2(DMEM_DEPTH);

	data_t			mem		[DMEM_DEPTH];

	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[write_address[INDEX_BITS-1:0]] <= write_data;
		end
	end

	always_ff @(posedge clock) begin
		if (read_en) begin
			read_data <= mem[read_address[INDEX_BITS-1:0]];	// Registered read
		end
	end

endmodule

//--- hdl/dmem_ctrl.sv
// Data memory controller
// Two clients share the memory through separate store and load burst paths

`timescale 1ns/10ps

module dmem_ctrl
	import tpu_types_pkg::*;
	import dmem_pkg::*;
#(
	parameter int DMEM_DEPTH = 256
)(
	input	logic			clock,
	input	logic			reset,
	input	logic			st_req			[2],	// Store burst strobe
	input	burst_req_t		st_desc			[2],
	input	logic			st_valid		[2],	// Store beat valid
	input	data_t			st_data			[2],
	output	logic			st_grant		[2],
	input	logic			ld_req			[2],	// Load burst strobe
	input	burst_req_t		ld_desc			[2],
	input	logic			ld_valid		[2],	// Load beat valid
	output	logic			ld_grant		[2],
	output	data_t			ld_data			[2],	// Zero unless strobed
	output	logic			ld_data_strobe	[2]
);

	logic			st_start;
	logic			ld_start;
	burst_req_t		st_active;
	burst_req_t		ld_active;
	logic			st_end;
	logic			ld_end;
	address_t		st_address;
	address_t		ld_address;

	logic			st_beat;
	logic			ld_beat_client	[2];
	logic			ld_beat;
	logic			ld_beat_q		[2];	// Client that issued last load beat
	data_t			st_word;
	data_t			read_data;

	////////////////////////////////////////////////////////////////////////////
	// Beat formation

	assign st_beat = (st_grant[0] & st_valid[0]) | (st_grant[1] & st_valid[1]);
	assign st_word = st_grant[1] ? st_data[1] : st_data[0];	// Granted client's data

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			ld_beat_client[i] = ld_grant[i] & ld_valid[i];
		end
	end

	assign ld_beat = ld_beat_client[0] | ld_beat_client[1];

	////////////////////////////////////////////////////////////////////////////
	// Load return steering

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_beat_q[0] <= 1'b0;
			ld_beat_q[1] <= 1'b0;
		end
		else begin
			ld_beat_q[0] <= ld_beat_client[0];
			ld_beat_q[1] <= ld_beat_client[1];
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			ld_data[i]        = ld_beat_q[i] ? read_data : '0;
			ld_data_strobe[i] = ld_beat_q[i];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Store path

	request_arbiter store_arb (
		.clock			(clock),
		.reset			(reset),
		.req			(st_req),
		.req_desc		(st_desc),
		.burst_end		(st_end),
		.grant			(st_grant),
		.active_desc	(st_active),
		.burst_start	(st_start)
	);

	agu #(
		.DMEM_DEPTH		(DMEM_DEPTH)
	) store_agu (
		.clock			(clock),
		.reset			(reset),
		.start			(st_start),
		.desc			(st_active),
		.beat			(st_beat),
		.address		(st_address),
		.end_access		(st_end)
	);

	////////////////////////////////////////////////////////////////////////////
	// Load path

	request_arbiter load_arb (
		.clock			(clock),
		.reset			(reset),
		.req			(ld_req),
		.req_desc		(ld_desc),
		.burst_end		(ld_end),
		.grant			(ld_grant),
		.active_desc	(ld_active),
		.burst_start	(ld_start)
	);

	agu #(
		.DMEM_DEPTH		(DMEM_DEPTH)
	) load_agu (
		.clock			(clock),
		.reset			(reset),
		.start			(ld_start),
		.desc			(ld_active),
		.beat			(ld_beat),
		.address		(ld_address),
		.end_access		(ld_end)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory

	dmem_array #(
		.DMEM_DEPTH		(DMEM_DEPTH)
	) dmem_array (
		.clock			(clock),
		.write_en		(st_beat),
		.write_address	(st_address),
		.write_data		(st_word),
		.read_en		(ld_beat),
		.read_address	(ld_address),
		.read_data		(read_data)
	);

endmodule

//--- verification/dmem_ctrl_properties.sv
// Request arbiter assertions
// Grant one-hot while busy, grant held until burst end, start only from idle

`timescale 1ns/10ps

module dmem_ctrl_properties
	import dmem_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			grant		[2],
	input	logic			burst_end,
	input	logic			burst_start,
	input	arb_state_t		state
);

	// One grant while busy and none while idle
	grant_exclusive: assert property (
		@(posedge clock) disable iff (reset)
		((state == ARB_BUSY) && (grant[0] != grant[1])) ||
		((state == ARB_IDLE) && !grant[0] && !grant[1])
	) else $error("Grant not one-hot while busy or not zero while idle");

	// Grant only drops after the final beat
	grant_0_held: assert property (
		@(posedge clock) disable iff (reset)
		(grant[0] && !burst_end) |=> grant[0]
	) else $error("Grant of client 0 fell without burst_end");

	grant_1_held: assert property (
		@(posedge clock) disable iff (reset)
		(grant[1] && !burst_end) |=> grant[1]
	) else $error("Grant of client 1 fell without burst_end");

	// Idle is the only state with no grant held
	start_when_idle: assert property (
		@(posedge clock) disable iff (reset)
		burst_start |-> !(grant[0] || grant[1])
	) else $error("burst_start while a grant is held");

endmodule

bind request_arbiter dmem_ctrl_properties arb_props (
	.clock			(clock),
	.reset			(reset),
	.grant			(grant),
	.burst_end		(burst_end),
	.burst_start	(burst_start),
	.state			(state)
);

//--- verification/dmem_ctrl_tb.sv
// Data memory controller testbench
// Vector-driven bursts checked against a model memory and a grant timing model

`timescale 1ns/10ps

module dmem_ctrl_tb
	import tpu_types_pkg::*;
	import dmem_pkg::*;
();

	logic			clock;
	logic			reset;
	logic			st_req			[2];
	burst_req_t		st_desc			[2];
	logic			st_valid		[2];
	data_t			st_data			[2];
	logic			st_grant		[2];
	logic			ld_req			[2];
	burst_req_t		ld_desc			[2];
	logic			ld_valid		[2];
	logic			ld_grant		[2];
	data_t			ld_data			[2];
	logic			ld_data_strobe	[2];

	logic [63:0]	vectors		[64];		// op, client, base, stride, length, gap, pair
	data_t			model_mem	[65536];
	logic [31:0]	rng = 32'd310;
	int				cycles = 0;
	int				cycle_limit = 100;

	// Model state indexed [direction][client] with direction 0 for store and 1 for load
	logic			start_req	[2][2];
	logic			active		[2][2];		// Burst issued and not finished
	logic			pend		[2][2];
	burst_req_t		pdesc		[2][2];
	logic			gap_mode	[2][2];
	logic			busy		[2];
	logic			owner		[2];
	logic			last_win	[2];
	burst_req_t		cur_desc	[2];
	int				beat_idx	[2];
	int				left		[2];
	logic			ret_strobe	[2];		// Load return due next cycle
	data_t			ret_word	[2];

	dmem_ctrl #(
		.DMEM_DEPTH		(256)
	) UUT (
		.clock			(clock),
		.reset			(reset),
		.st_req			(st_req),
		.st_desc		(st_desc),
		.st_valid		(st_valid),
		.st_data		(st_data),
		.st_grant		(st_grant),
		.ld_req			(ld_req),
		.ld_desc		(ld_desc),
		.ld_valid		(ld_valid),
		.ld_grant		(ld_grant),
		.ld_data		(ld_data),
		.ld_data_strobe	(ld_data_strobe)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles > cycle_limit) begin
			abort_run($sformatf("Timeout: bursts still running after %0d cycles", cycle_limit));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers and compare tasks

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic check_address(input string name, input address_t actual,
			input address_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic check_grant(input string name, input logic [1:0] actual,
			input logic [1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Beat i lands at base + i * stride wrapped to the memory depth
	function automatic address_t burst_address(input burst_req_t desc, input int i);
		return address_t'((int'(desc.base) + i * int'(desc.stride)) % UUT.DMEM_DEPTH);
	endfunction

	task automatic issue_burst(input logic [63:0] v);
		int d;
		int c;
		d = int'(v[60]);
		c = int'(v[56]);
		start_req[d][c] = 1'b1;
		active[d][c]    = 1'b1;
		pdesc[d][c]     = v[55:8];
		gap_mode[d][c]  = v[4];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One clock cycle of checks, stimulus and model update

	task automatic run_cycle();
		logic [1:0]		expected;
		logic [1:0]		actual;
		logic			was_busy;
		logic			valid;
		logic			win;
		address_t		addr;
		check_grant("ld_data_strobe", {ld_data_strobe[1], ld_data_strobe[0]},
			{ret_strobe[1], ret_strobe[0]});
		for (int c = 0; c < 2; c++) begin
			check_data($sformatf("ld_data[%0d]", c), ld_data[c], ret_word[c]);	// Zero if idle
			ret_strobe[c] = 1'b0;
			ret_word[c]   = '0;
			st_req[c]     = start_req[0][c];
			ld_req[c]     = start_req[1][c];
			st_desc[c]    = pdesc[0][c];
			ld_desc[c]    = pdesc[1][c];
			for (int d = 0; d < 2; d++) begin
				pend[d][c]      = pend[d][c] | start_req[d][c];
				start_req[d][c] = 1'b0;
			end
			rng         = xorshift(rng);
			st_data[c]  = rng;
			st_valid[c] = active[0][c] & (~gap_mode[0][c] | rng[7]);
			ld_valid[c] = active[1][c] & (~gap_mode[1][c] | rng[11]);
		end

		// Loads first so a read sees the word from before a same-cycle write
		for (int d = 1; d >= 0; d--) begin
			expected = busy[d] ? (2'b01 << owner[d]) : 2'b00;
			actual   = d ? {ld_grant[1], ld_grant[0]} : {st_grant[1], st_grant[0]};
			check_grant(d ? "ld_grant" : "st_grant", actual, expected);
			was_busy = busy[d];
			valid    = d ? ld_valid[owner[d]] : st_valid[owner[d]];
			if (busy[d] && valid) begin
				addr = burst_address(cur_desc[d], beat_idx[d]);
				if (d == 0) begin
					check_address("store_agu.address", UUT.store_agu.address, addr);
					model_mem[addr] = st_data[owner[d]];
				end
				else begin
					check_address("load_agu.address", UUT.load_agu.address, addr);
					ret_strobe[owner[d]] = 1'b1;
					ret_word[owner[d]]   = model_mem[addr];
				end
				beat_idx[d]++;
				left[d]--;
				if (left[d] == 0) begin
					busy[d]              = 1'b0;	// Grant drops next cycle
					active[d][owner[d]]  = 1'b0;
				end
			end
			if (!was_busy && (pend[d][0] | pend[d][1])) begin
				win              = (pend[d][0] & pend[d][1]) ? ~last_win[d] : pend[d][1];
				last_win[d]      = win;
				pend[d][win]     = 1'b0;
				busy[d]          = 1'b1;
				owner[d]         = win;
				cur_desc[d]      = pdesc[d][win];
				beat_idx[d]      = 0;
				left[d]          = (pdesc[d][win].length == '0) ? 1 : int'(pdesc[d][win].length);
			end
		end
		@(posedge clock);
		#0.5;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int				i;
		logic [63:0]	v;
		clock = 1'b0;
		reset = 1'b1;
		for (int c = 0; c < 2; c++) begin
			st_req[c]   = 1'b0;
			st_desc[c]  = '0;
			st_valid[c] = 1'b0;
			st_data[c]  = '0;
			ld_req[c]   = 1'b0;
			ld_desc[c]  = '0;
			ld_valid[c] = 1'b0;
			ret_strobe[c] = 1'b0;
			ret_word[c]   = '0;
			busy[c]       = 1'b0;
			owner[c]      = 1'b0;
			last_win[c]   = 1'b1;					// Client 0 takes the first tie
			for (int d = 0; d < 2; d++) begin
				start_req[c][d] = 1'b0;
				active[c][d]    = 1'b0;
				pend[c][d]      = 1'b0;
				pdesc[c][d]     = '0;
				gap_mode[c][d]  = 1'b0;
			end
		end

		$readmemh("verification/dmem_vectors.txt", vectors);
		if ($isunknown(vectors[0])) begin
			abort_run("Vector file verification/dmem_vectors.txt could not be read");
		end
		for (i = 0; i < 64 && vectors[i][63:60] !== 4'hf; i++) begin
			cycle_limit += 4 * ((vectors[i][23:8] == 0) ? 1 : int'(vectors[i][23:8]));
		end

		repeat (2) @(posedge clock);
		#0.5;
		reset = 1'b0;
		repeat (3) run_cycle();						// Grants and strobes stay low

		i = 0;
		while (i < 64 && vectors[i][63:60] !== 4'hf) begin
			// Lines with the pair flag start in the same cycle as the next one
			do begin
				v = vectors[i];
				issue_burst(v);
				i++;
			end while (v[3:0] != 4'h0 && i < 64);
			do begin
				run_cycle();
			end while (active[0][0] | active[0][1] | active[1][0] | active[1][1]);
			run_cycle();							// Last load word and grant fall
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- verification/dmem_vectors.txt
// One burst per line in hex: op (0 store, 1 load) _ client _ base _ stride _ length
// _ gap (1 random valid gaps) _ pair (1 starts in the same cycle as the next line)
// Unit stride store, then load back on both clients
0_0_0000_0001_0010_0_0
1_0_0000_0001_0010_0_0
1_1_0004_0001_0008_1_0
// Stride 3 burst that wraps past the top of memory
0_1_00f8_0003_0010_0_0
1_0_00f8_0003_0010_1_0
// Both clients store in one cycle, then both load
0_0_0040_0001_0008_0_1
0_1_0060_0002_0006_1_0
1_0_0060_0002_0006_1_1
1_1_0040_0001_0008_0_0
0_1_0080_0001_0008_0_1
0_0_0090_0004_0004_0_0
// Store and load paths together on disjoint regions
0_1_00a0_0001_0010_1_1
1_0_0040_0001_0008_0_0
// Zero length makes a single beat
0_0_00c0_0005_0000_0_0
1_1_00c0_0005_0000_0_0
// All four request strobes in one cycle
0_0_00d0_0001_0004_0_1
0_1_00e0_0001_0004_1_1
1_0_0080_0001_0008_1_1
1_1_0090_0004_0004_0_0
// End marker
f_0_0000_0000_0000_0_0

//--- all.f
hdl/tpu_types_pkg.sv
hdl/dmem_pkg.sv
hdl/request_arbiter.sv
hdl/agu.sv
hdl/dmem_array.sv
hdl/dmem_ctrl.sv
verification/dmem_ctrl_properties.sv
verification/dmem_ctrl_tb.sv

//--- Bender.yml
package:
  name: dmem_ctrl

sources:
  - files:
      - hdl/tpu_types_pkg.sv
      - hdl/dmem_pkg.sv
      - hdl/request_arbiter.sv
      - hdl/agu.sv
      - hdl/dmem_array.sv
      - hdl/dmem_ctrl.sv
  - target: test
    files:
      - verification/dmem_ctrl_properties.sv
      - verification/dmem_ctrl_tb.sv
